// File: Makefile
# Verilator flow for rx_ctrl, override any variable on the command line

VERILATOR  ?= verilator
FILELIST   ?= rx_ctrl.f
TB_TOP     ?= tb_rx_ctrl
RTL_TOP    ?= rx_ctrl
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
FAIL_MSG   ?= Some tests failed
PASS_MSG   ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rx_ctrl.f
spio_rx_pkg.sv
rx_word_if.sv
rx_word_align.sv
rx_sync_track.sv
rx_out_stage.sv
rx_ctrl.sv
rx_ctrl_asserts.sv
tb_rx_ctrl.sv

// File: rx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rx_ctrl (
  input  logic                      clk,
  input  logic                      rst,

  // from the transceiver
  input  spio_rx_pkg::word_t        gtp_data,
  input  spio_rx_pkg::kflag_t       gtp_kchr,
  input  spio_rx_pkg::kflag_t       gtp_is_comma,
  input  logic                      gtp_byte_is_aligned,
  input  logic [1:0]                gtp_los,

  // back to the transceiver
  output logic                      rx_align_comma,

  // training status
  output spio_rx_pkg::train_state_t rx_state,

  // forwarded data words
  output spio_rx_pkg::word_t        rx_out_data,
  output spio_rx_pkg::kflag_t       rx_out_kchr,
  output logic                      rx_out_vld
);

  // aligned word shared by all three blocks
  rx_word_if word_bus ();

  // ------------------------------
  // word aligner
  // ------------------------------
  rx_word_align u_align (
    .clk                 (clk),
    .rst                 (rst),
    .gtp_data            (gtp_data),
    .gtp_kchr            (gtp_kchr),
    .gtp_is_comma        (gtp_is_comma),
    .gtp_byte_is_aligned (gtp_byte_is_aligned),
    .gtp_los             (gtp_los),
    .word                (word_bus.align)
  );

  // ------------------------------
  // training tracker
  // ------------------------------
  rx_sync_track u_track (
    .clk         (clk),
    .rst         (rst),
    .word        (word_bus.track),
    .align_comma (rx_align_comma),
    .rx_state    (rx_state)
  );

  // ------------------------------
  // output stage
  // ------------------------------
  rx_out_stage u_out (
    .clk         (clk),
    .rst         (rst),
    .word        (word_bus.out),
    .rx_out_data (rx_out_data),
    .rx_out_kchr (rx_out_kchr),
    .rx_out_vld  (rx_out_vld)
  );

endmodule

`default_nettype wire

// File: rx_ctrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module rx_ctrl_asserts (
  input logic                      clk,
  input logic                      rst,
  input logic                      rx_align_comma,
  input spio_rx_pkg::train_state_t rx_state,
  input logic                      rx_out_vld
);

  // ------------------------------
  // training status
  // ------------------------------
  // alignment request only comes back with reset
  align_req_stays_low: assert property (
    @(posedge clk) disable iff (rst) !$past(rx_align_comma) |-> !rx_align_comma
  ) else $error("rx_align_comma rose again after it fell");

  // state only moves forward
  state_no_backstep: assert property (
    @(posedge clk) disable iff (rst) rx_state >= $past(rx_state)
  ) else $error("rx_state stepped back to %0d", rx_state);

  // ------------------------------
  // output
  // ------------------------------
  out_only_locked: assert property (
    @(posedge clk) disable iff (rst) rx_out_vld |-> (rx_state == spio_rx_pkg::TRAIN_LOCKED)
  ) else $error("rx_out_vld high while rx_state is %0d", rx_state);

endmodule

bind rx_ctrl rx_ctrl_asserts u_asserts (
  .clk            (clk),
  .rst            (rst),
  .rx_align_comma (rx_align_comma),
  .rx_state       (rx_state),
  .rx_out_vld     (rx_out_vld)
);

`default_nettype wire

// File: rx_out_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rx_out_stage (
  input  logic                 clk,
  input  logic                 rst,
  rx_word_if.out               word,
  output spio_rx_pkg::word_t   rx_out_data,
  output spio_rx_pkg::kflag_t  rx_out_kchr,
  output logic                 rx_out_vld
);

  // ------------------------------
  // filler detection
  // ------------------------------
  logic is_sync;  // training frame, also sent after lock
  logic is_clkc;  // clock correction
  logic is_ok;    // data word to forward

  assign is_sync = spio_rx_pkg::is_sync_frame(word.data, word.kchr);
  assign is_clkc = spio_rx_pkg::is_clkc_frame(word.data, word.kchr);

  // nothing leaves before lock
  assign is_ok = word.vld && !is_sync && !is_clkc
                 && (word.state == spio_rx_pkg::TRAIN_LOCKED);

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (is_ok) begin
      rx_out_data <= word.data;  // hold last word otherwise
      rx_out_kchr <= word.kchr;
    end
  end

  // one-cycle strobe per forwarded word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_out_vld <= 1'b0;
    end else begin
      rx_out_vld <= is_ok;
    end
  end

endmodule

`default_nettype wire

// File: rx_sync_track.sv
`timescale 1ns/100ps
`default_nettype none

module rx_sync_track (
  input  logic                      clk,
  input  logic                      rst,
  rx_word_if.track                  word,
  output logic                      align_comma,
  output spio_rx_pkg::train_state_t rx_state
);

  // ------------------------------
  // internal signals
  // ------------------------------
  logic                      is_sync;   // valid sync frame on the aligned word
  spio_rx_pkg::sync_cnt_t    cnt [4];   // frames seen per phase
  logic [2:0]                cnt_full;  // phase reached threshold, phases 0..2
  logic [3:1]                cnt_over;  // phase went past threshold, phases 1..3
  spio_rx_pkg::train_state_t state_q;
  spio_rx_pkg::train_state_t state_d;

  // only count while the aligned word is valid
  assign is_sync = word.vld && spio_rx_pkg::is_sync_frame(word.data, word.kchr);

  // ------------------------------
  // per-phase counters
  // ------------------------------
  for (genvar p = 0; p < 4; p++) begin : g_phase
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        cnt[p] <= '0;
      end else if (is_sync && (word.data[23:16] == 8'(p)) && (cnt[p] != '1)) begin
        cnt[p] <= cnt[p] + spio_rx_pkg::sync_cnt_t'(1);  // sticks at max, no wrap
      end
    end

    // own phase done, phases 0..2
    if (p < 3) begin : g_full
      assign cnt_full[p] = (cnt[p] >= spio_rx_pkg::SYNC_CNT);
    end

    // far end ahead, phases 1..3
    if (p > 0) begin : g_over
      assign cnt_over[p] = (cnt[p] >  spio_rx_pkg::SYNC_CNT);
    end
  end

  // ------------------------------
  // training FSM
  // ------------------------------
  // advance on enough frames of this phase, or more than enough of the next
  // (far end may already have moved on)
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      spio_rx_pkg::TRAIN_PH0:
        if (cnt_full[0] || cnt_over[1]) state_d = spio_rx_pkg::TRAIN_PH1;
      spio_rx_pkg::TRAIN_PH1:
        if (cnt_full[1] || cnt_over[2]) state_d = spio_rx_pkg::TRAIN_PH2;
      spio_rx_pkg::TRAIN_PH2:
        if (cnt_full[2] || cnt_over[3]) state_d = spio_rx_pkg::TRAIN_LOCKED;
      default:
        state_d = spio_rx_pkg::TRAIN_LOCKED;  // locked until reset
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= spio_rx_pkg::TRAIN_PH0;
    end else begin
      state_q <= state_d;
    end
  end

  assign word.state = state_q;

  // exported copy, one cycle behind
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_state <= spio_rx_pkg::TRAIN_PH0;
    end else begin
      rx_state <= state_q;
    end
  end

  // ask for comma alignment until locked, then never again
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      align_comma <= 1'b1;
    end else if (state_q == spio_rx_pkg::TRAIN_LOCKED) begin
      align_comma <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rx_word_align.sv
`timescale 1ns/100ps
`default_nettype none

module rx_word_align (
  input  logic                clk,
  input  logic                rst,
  input  spio_rx_pkg::word_t  gtp_data,
  input  spio_rx_pkg::kflag_t gtp_kchr,
  input  spio_rx_pkg::kflag_t gtp_is_comma,
  input  logic                gtp_byte_is_aligned,
  input  logic [1:0]          gtp_los,
  rx_word_if.align            word
);

  // ------------------------------
  // internal signals
  // ------------------------------
  logic                accept;     // raw word usable this cycle
  spio_rx_pkg::kflag_t alignment;  // one-hot comma position, 0 = none yet
  logic [23:0]         data_buf;   // bytes 3..1 of the previous word
  logic [2:0]          kchr_buf;   // their K flags

  // once locked the transceiver may drop byte-aligned, keep going
  // los[1] high means real loss of sync
  assign accept = (gtp_byte_is_aligned || (word.state == spio_rx_pkg::TRAIN_LOCKED))
                  && !gtp_los[1];

  // ------------------------------
  // comma position
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      alignment <= '0;
    end else if (!accept) begin
      alignment <= '0;            // lost it, wait for next comma
    end else if (gtp_is_comma != '0) begin
      alignment <= gtp_is_comma;  // new comma, new offset
    end
  end

  // byte buffer, payload only
  // byte 0 is never needed from the old word
  always_ff @(posedge clk) begin
    if (accept) begin
      data_buf <= gtp_data[31:8];
      kchr_buf <= gtp_kchr[3:1];
    end
  end

  // ------------------------------
  // realignment
  // ------------------------------
  // comma in byte n of the raw word: raw bytes n..0 go on top,
  // buffered bytes 3..n+1 fill the bottom
  always_comb begin
    unique case (alignment)
      4'b0001: begin
        word.data = {gtp_data[7:0], data_buf[23:0]};
        word.kchr = {gtp_kchr[0], kchr_buf[2:0]};
      end
      4'b0010: begin
        word.data = {gtp_data[15:0], data_buf[23:8]};
        word.kchr = {gtp_kchr[1:0], kchr_buf[2:1]};
      end
      4'b0100: begin
        word.data = {gtp_data[23:0], data_buf[23:16]};
        word.kchr = {gtp_kchr[2:0], kchr_buf[2]};
      end
      default: begin
        word.data = gtp_data;  // comma already on top, or no alignment
        word.kchr = gtp_kchr;
      end
    endcase
  end

  // valid only once a comma has been seen
  assign word.vld = accept && (alignment != '0);

endmodule

`default_nettype wire

// File: rx_word_if.sv
`timescale 1ns/100ps
`default_nettype none

// aligned word as seen by tracker and output stage
interface rx_word_if;

  spio_rx_pkg::word_t        data;   // comma byte in the msbs
  spio_rx_pkg::kflag_t       kchr;   // K flags in the same byte order
  logic                      vld;    // accepted and aligned
  spio_rx_pkg::train_state_t state;  // training progress

  // aligner builds the word, needs state for the accept rule
  modport align (
    output data, kchr, vld,
    input  state
  );

  // tracker counts sync frames and owns the state
  modport track (
    input  data, kchr, vld,
    output state
  );

  // output stage only looks
  modport out (
    input data, kchr, vld, state
  );

endinterface

`default_nettype wire

// File: spio_rx_pkg.sv
`default_nettype none

package spio_rx_pkg;

  // ------------------------------
  // link word types
  // ------------------------------
  typedef logic [31:0] word_t;   // four decoded bytes, byte 3 in the msbs
  typedef logic [3:0]  kflag_t;  // one bit per byte, K flags or comma position

  // training progress, one state per sync phase
  typedef enum logic [1:0] {
    TRAIN_PH0    = 2'd0,
    TRAIN_PH1    = 2'd1,
    TRAIN_PH2    = 2'd2,
    TRAIN_LOCKED = 2'd3
  } train_state_t;

  // ------------------------------
  // sync frame counting
  // ------------------------------
  localparam int SYNC_CNT_W = 7;

  typedef logic [SYNC_CNT_W-1:0] sync_cnt_t;

  localparam sync_cnt_t SYNC_CNT = 7'd100;  // frames needed per phase

  // ------------------------------
  // link characters
  // ------------------------------
  localparam logic [7:0] COMMA_CHR  = 8'hBC;        // K28.5
  localparam logic [7:0] SYNC_CHR   = 8'h1C;        // K28.0
  localparam kflag_t     SYNC_KBITS = 4'b1010;      // comma and sync bytes are K
  localparam word_t      CLKC_FRM   = {4{8'hF7}};   // K23.7 in every byte
  localparam kflag_t     CLKC_KBITS = 4'b1111;

  // sync frame layout: comma | phase | sync | don't care
  function automatic logic is_sync_frame(input word_t data, input kflag_t kchr);
    return (kchr == SYNC_KBITS) && (data[31:24] == COMMA_CHR)
           && (data[15:8] == SYNC_CHR);
  endfunction

  // clock correction, all four bytes fixed
  function automatic logic is_clkc_frame(input word_t data, input kflag_t kchr);
    return (kchr == CLKC_KBITS) && (data == CLKC_FRM);
  endfunction

endpackage

`default_nettype wire

// File: tb_rx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rx_ctrl;

  localparam int CLK_PERIOD = 4;
  localparam int N_SYNC     = int'(spio_rx_pkg::SYNC_CNT);
  localparam int N_DATA     = 200;  // data frames in test 4
  localparam int N_MIX      = 300;  // mixed frames in test 5
  localparam int N_RESUME   = 100;  // data frames after loss of sync
  // about one word per frame, two trainings, plus waits and resets
  localparam int WATCHDOG_CYCLES = 2 * (9 * N_SYNC + N_DATA + N_MIX + N_RESUME) + 2000;

  logic                      clk;
  logic                      rst;
  spio_rx_pkg::word_t        gtp_data;
  spio_rx_pkg::kflag_t       gtp_kchr;
  spio_rx_pkg::kflag_t       gtp_is_comma;
  logic                      gtp_byte_is_aligned;
  logic [1:0]                gtp_los;
  logic                      rx_align_comma;
  spio_rx_pkg::train_state_t rx_state;
  spio_rx_pkg::word_t        rx_out_data;
  spio_rx_pkg::kflag_t       rx_out_kchr;
  logic                      rx_out_vld;

  // ------------------------------
  // byte stream and model
  // ------------------------------
  logic [7:0]          byte_q[$];      // earliest byte first, frame byte 0 goes out first
  logic                kbit_q[$];
  logic                comma_q[$];
  spio_rx_pkg::word_t  exp_data_q[$];  // data frames still to come out
  spio_rx_pkg::kflag_t exp_kchr_q[$];

  int    errors = 0;
  int    test_errors = 0;  // error count when the test started
  int    tests_run = 0;
  int    tests_failed = 0;
  int    out_count = 0;    // rx_out_vld pulses seen
  int    offset = 0;       // filler bytes ahead of the first frame
  int    out_before = 0;
  string test_name;

  rx_ctrl DUT (
    .clk                 (clk),
    .rst                 (rst),
    .gtp_data            (gtp_data),
    .gtp_kchr            (gtp_kchr),
    .gtp_is_comma        (gtp_is_comma),
    .gtp_byte_is_aligned (gtp_byte_is_aligned),
    .gtp_los             (gtp_los),
    .rx_align_comma      (rx_align_comma),
    .rx_state            (rx_state),
    .rx_out_data         (rx_out_data),
    .rx_out_kchr         (rx_out_kchr),
    .rx_out_vld          (rx_out_vld)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // ------------------------------
  // checks
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // outputs settle after the rising edge, look at them on the falling one
  always @(negedge clk) begin
    if (!rst && rx_out_vld) begin
      out_count++;
      if (exp_data_q.size() == 0) begin
        check_true(1'b0, "rx_out_vld pulsed with no data word outstanding");
      end else begin
        check_value("rx_out_data", rx_out_data, exp_data_q.pop_front());
        check_value("rx_out_kchr", 32'(rx_out_kchr), 32'(exp_kchr_q.pop_front()));
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic push_frame(input spio_rx_pkg::word_t data, input spio_rx_pkg::kflag_t kchr,
                            input logic comma);
    for (int b = 0; b < 4; b++) begin
      byte_q.push_back(data[8*b +: 8]);
      kbit_q.push_back(kchr[b]);
      comma_q.push_back(comma && (b == 3));  // comma sits in byte 3
    end
  endtask

  task automatic push_sync(input int phase);
    push_frame({spio_rx_pkg::COMMA_CHR, 8'(phase), spio_rx_pkg::SYNC_CHR, 8'($urandom)},
               spio_rx_pkg::SYNC_KBITS, 1'b1);
  endtask

  task automatic push_data(input logic expect_out);
    spio_rx_pkg::word_t  d;
    spio_rx_pkg::kflag_t k;
    d = $urandom;
    k = spio_rx_pkg::kflag_t'($urandom % 8);  // top byte never K, can't look like filler
    push_frame(d, k, 1'b0);
    if (expect_out) begin
      exp_data_q.push_back(d);
      exp_kchr_q.push_back(k);
    end
  endtask

  // cut the stream into words, leftover bytes wait for more frames
  task automatic send_words();
    spio_rx_pkg::word_t  d;
    spio_rx_pkg::kflag_t k;
    spio_rx_pkg::kflag_t c;
    while (byte_q.size() >= 4) begin
      for (int b = 0; b < 4; b++) begin
        d[8*b +: 8] = byte_q.pop_front();
        k[b]        = kbit_q.pop_front();
        c[b]        = comma_q.pop_front();
      end
      @(posedge clk);
      gtp_data     <= d;
      gtp_kchr     <= k;
      gtp_is_comma <= c;
      gtp_los      <= 2'b00;
    end
  endtask

  // idle link keeps sending clock correction
  task automatic pump_idle(input int n);
    repeat (n) begin
      push_frame(spio_rx_pkg::CLKC_FRM, spio_rx_pkg::CLKC_KBITS, 1'b0);
      send_words();
    end
  endtask

  task automatic restart_stream(input int new_offset);
    byte_q.delete();
    kbit_q.delete();
    comma_q.delete();
    offset = new_offset;
    repeat (offset) begin
      byte_q.push_back(8'($urandom));
      kbit_q.push_back(1'b0);
      comma_q.push_back(1'b0);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst          <= 1'b1;
    gtp_data     <= '0;
    gtp_kchr     <= '0;
    gtp_is_comma <= '0;
    gtp_los      <= 2'b00;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    exp_data_q.delete();
    exp_kchr_q.delete();
    restart_stream($urandom % 4);
  endtask

  // random garbage with los[1] high
  task automatic link_down(input int n);
    repeat (n) begin
      @(posedge clk);
      gtp_data     <= $urandom;
      gtp_kchr     <= 4'($urandom);
      gtp_is_comma <= 4'($urandom);
      gtp_los      <= 2'b10;
    end
  endtask

  task automatic wait_for_state(input spio_rx_pkg::train_state_t expected, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while ((rx_state != expected) && (n < limit)) begin
      pump_idle(1);
      @(negedge clk);
      n++;
    end
    check_value("rx_state", 32'(rx_state), 32'(expected));
  endtask

  task automatic drain_outputs(input int limit);
    int n;
    n = 0;
    while ((exp_data_q.size() != 0) && (n < limit)) begin
      pump_idle(1);
      n++;
    end
    @(negedge clk);
    check_true(exp_data_q.size() == 0,
               $sformatf("%0d data words never came out", exp_data_q.size()));
  endtask

  // lead frame only sets the alignment, then SYNC_CNT frames per phase
  task automatic train_link();
    push_sync(0);
    for (int p = 0; p < 3; p++) begin
      for (int i = 0; i < N_SYNC; i++) begin
        if ($urandom % 4 == 0) push_data(1'b0);  // must be dropped before lock
        push_sync(p);
      end
      send_words();
      wait_for_state(spio_rx_pkg::train_state_t'(p + 1), 20);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, test_name, errors - test_errors);
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    rst                 = 1'b1;
    gtp_data            = '0;
    gtp_kchr            = '0;
    gtp_is_comma        = '0;
    gtp_byte_is_aligned = 1'b1;  // held high throughout
    gtp_los             = 2'b00;
    void'($urandom(32'heece9884));

    start_test("reset values");
    apply_reset();
    @(negedge clk);
    check_value("rx_align_comma", 32'(rx_align_comma), 32'd1);
    check_value("rx_state", 32'(rx_state), 32'(spio_rx_pkg::TRAIN_PH0));
    check_value("rx_out_vld", 32'(rx_out_vld), 32'd0);
    end_test();

    start_test("training");
    train_link();
    check_value("rx_align_comma", 32'(rx_align_comma), 32'd0);  // drops with rx_state
    drain_outputs(20);
    end_test();

    start_test("phase skip");
    apply_reset();
    push_sync(0);
    repeat (N_SYNC) push_sync(1);  // next phase only, exactly at the threshold
    send_words();
    pump_idle(6);
    @(negedge clk);
    check_value("rx_state", 32'(rx_state), 32'(spio_rx_pkg::TRAIN_PH0));  // not past it yet
    push_sync(1);  // one past the threshold
    send_words();
    wait_for_state(spio_rx_pkg::TRAIN_PH2, 20);
    pump_idle(4);
    @(negedge clk);
    check_value("rx_state", 32'(rx_state), 32'(spio_rx_pkg::TRAIN_PH2));  // no phase 2 frames yet
    end_test();

    start_test("data after lock");
    apply_reset();
    train_link();
    repeat (N_DATA) push_data(1'b1);
    send_words();
    drain_outputs(20);
    end_test();

    start_test("filler dropped");
    repeat (N_MIX) begin
      case ($urandom % 10)
        0, 1, 2, 3, 4, 5: push_data(1'b1);
        6, 7:             push_frame(spio_rx_pkg::CLKC_FRM, spio_rx_pkg::CLKC_KBITS, 1'b0);
        default:          push_sync($urandom % 4);
      endcase
    end
    send_words();
    drain_outputs(20);
    end_test();

    start_test("loss of sync");
    out_before = out_count;
    link_down(16);
    @(negedge clk);
    check_true(out_count == out_before, "rx_out_vld pulsed while loss of sync was high");
    restart_stream((offset + 1 + $urandom % 3) % 4);  // always a different offset
    push_sync(0);
    repeat (N_RESUME) begin
      if ($urandom % 5 == 0) push_frame(spio_rx_pkg::CLKC_FRM, spio_rx_pkg::CLKC_KBITS, 1'b0);
      push_data(1'b1);
    end
    send_words();
    drain_outputs(20);
    link_down(2);  // quiet link before the end
    end_test();

    $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
